// File: logic/fifo_ptr_pkg.sv
//--------------------------------------------------------------------------
// pointer and usage types shared by the fifo head and tail controllers
// and the wrap rule that keeps a pointer inside the configured region
//--------------------------------------------------------------------------
`default_nettype none

package fifo_ptr_pkg;

  // ram address width used by the region bounds and all pointers
  parameter int ADDR_W = 6;

  // one ram address inside the fifo region
  typedef logic [ADDR_W-1:0] fifo_ptr_t;

  // word count one bit wider so that a full 2**ADDR_W region still fits
  typedef logic [ADDR_W:0] fifo_usage_t;

  // next pointer position wraps back to the low bound after the high bound
  function automatic fifo_ptr_t ptr_next(
    input fifo_ptr_t ptr,
    input fifo_ptr_t low,
    input fifo_ptr_t high
  );
    fifo_ptr_t nxt;
    if (ptr == high)
      nxt = low;
    else
      nxt = ptr + fifo_ptr_t'(1);
    return nxt;
  endfunction

endpackage

`default_nettype wire

// File: logic/fifo_data_pkg.sv
//--------------------------------------------------------------------------
// data path types: the stored fifo word and the read item that carries
// its ram address through the tail output buffers
//--------------------------------------------------------------------------
`default_nettype none

package fifo_data_pkg;

  import fifo_ptr_pkg::*;

  // payload width of one fifo entry
  parameter int DATA_W = 16;

  // one word as stored in the ram
  typedef struct packed {
    logic [DATA_W-1:0] data;
  } fifo_word_t;

  // word returned by the ram, tagged with the address it came from
  // the tag is what lets a commit move the commit pointer
  typedef struct packed {
    fifo_word_t        word;
    logic [ADDR_W-1:0] addr;
  } read_item_t;

endpackage

`default_nettype wire

// File: logic/read_buffer.sv
//--------------------------------------------------------------------------
// two entry valid/ready buffer made of an output slot and a skid slot
// in_ready looks only at occupancy and reset also serves as flush
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module read_buffer
  import fifo_data_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,

  // upstream side
  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire read_item_t in_item,

  // downstream side
  output logic            out_valid,
  input  wire logic       out_ready,
  output read_item_t      out_item
);

  // slot0 is the head of the buffer and slot1 the skid entry
  read_item_t slot0;
  read_item_t slot1;
  logic       full0;
  logic       full1;
  logic       push;
  logic       pop;

  assign out_valid = full0;
  assign out_item  = slot0;

  // room as long as the skid slot is free
  assign in_ready = !full1;

  assign push = in_valid & in_ready;
  assign pop  = full0 & out_ready;

  //--------------------------------------------------------------------------
  // occupancy
  //--------------------------------------------------------------------------

  // slot1 only holds data while slot0 does so order is kept
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full0 <= 1'b0;
      full1 <= 1'b0;
    end
    else if (push && !pop)
    begin
      full0 <= 1'b1;
      full1 <= full0;
    end
    else if (pop && !push)
    begin
      full0 <= full1;
      full1 <= 1'b0;
    end
  end

  //--------------------------------------------------------------------------
  // payload
  //--------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      // the skid entry moves up, or else the incoming word takes slot0
      slot0 <= full1 ? slot1 : in_item;
    end
    else if (push)
    begin
      if (!full0)
        slot0 <= in_item;
      else
        slot1 <= in_item;
    end
  end

endmodule

`default_nettype wire

// File: logic/fifo_head.sv
//--------------------------------------------------------------------------
// fifo write controller, accepts producer words and writes them to the ram
// full is judged against the commit pointer handed back by the tail
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_head
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,

  // region of the ram owned by this fifo
  input  wire fifo_ptr_t  bound_low,
  input  wire fifo_ptr_t  bound_high,

  // oldest word that may still be replayed
  input  wire fifo_ptr_t  com_rdptr,

  // producer port
  input  wire logic       c_valid,
  output logic            c_ready,
  input  wire fifo_word_t c_data,

  // write pointer for the tail empty and usage logic
  output fifo_ptr_t       wrptr,

  // ram write port
  output logic            mem_we,
  output fifo_ptr_t       wr_addr,
  output fifo_word_t      wr_data
);

  // pointer position after the next accepted word
  fifo_ptr_t wrptr_p1;

  //--------------------------------------------------------------------------
  // full detection
  //--------------------------------------------------------------------------

  // one slot always stays empty so full and empty differ
  // comparing with the commit pointer protects uncommitted words
  assign wrptr_p1 = ptr_next(wrptr, bound_low, bound_high);
  assign c_ready  = (wrptr_p1 != com_rdptr);

  //--------------------------------------------------------------------------
  // ram write
  //--------------------------------------------------------------------------

  // the accepted word lands in the ram on the transfer edge
  assign mem_we  = c_valid & c_ready;
  assign wr_addr = wrptr;
  assign wr_data = c_data;

  // write pointer moves on the same edge as the ram write
  always_ff @(posedge clk)
  begin
    if (reset)
      wrptr <= bound_low;
    else if (mem_we)
      wrptr <= wrptr_p1;
  end

endmodule

`default_nettype wire

// File: logic/fifo_ram.sv
//--------------------------------------------------------------------------
// dual port storage for the fifo, one write port and one read port whose
// data shows up on rd_data the cycle after mem_re
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_ram
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
#(
  // number of words, at most 2**ADDR_W
  parameter int depth = 64
)
(
  input  wire logic       clk,

  // write side, driven by the head
  input  wire logic       mem_we,
  input  wire fifo_ptr_t  wr_addr,
  input  wire fifo_word_t wr_data,

  // read side, driven by the tail
  input  wire logic       mem_re,
  input  wire fifo_ptr_t  rd_addr,
  output fifo_word_t      rd_data
);

  fifo_word_t mem [depth];

  // synchronous write
  always_ff @(posedge clk)
  begin
    if (mem_we)
      mem[wr_addr] <= wr_data;
  end

  // registered read, holds its value when no read is issued
  always_ff @(posedge clk)
  begin
    if (mem_re)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: logic/fifo_tail.sv
//--------------------------------------------------------------------------
// fifo read controller, issues ram reads and buffers the returned words for
// the consumer; in commit mode it keeps a commit pointer and handles abort
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_tail
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
#(
  // 1 enables commit and abort, 0 lets the commit pointer track reads
  parameter int commit_mode = 1
)
(
  input  wire logic       clk,
  input  wire logic       reset,

  // fifo region and write pointer from the head
  input  wire fifo_ptr_t  bound_low,
  input  wire fifo_ptr_t  bound_high,
  input  wire fifo_ptr_t  wrptr,

  // read pointer doubles as the ram read address
  output fifo_ptr_t       cur_rdptr,
  output fifo_ptr_t       com_rdptr,
  output logic            mem_re,
  input  wire fifo_word_t rd_data,

  // consumer port
  output logic            p_valid,
  input  wire logic       p_ready,
  output fifo_word_t      p_data,
  input  wire logic       p_commit,
  input  wire logic       p_abort,

  // written but not yet committed words
  output fifo_usage_t     usage
);

  fifo_ptr_t   cur_rdptr_p1;
  fifo_ptr_t   nxt_com_rdptr;
  fifo_ptr_t   rdaddr_s0;
  fifo_usage_t fifo_size;
  logic        empty;
  logic        abort;
  logic        commit_xfer;
  logic        prev_re;
  logic        flush;

  // buffer chain between ram and consumer
  read_item_t  ram_item;
  logic        rb1_ready;
  logic        ip_valid;
  logic        ip_ready;
  read_item_t  ip_item;
  read_item_t  p_item;

  // commit and abort only count in commit mode
  assign abort       = (commit_mode != 0) && p_abort;
  assign commit_xfer = (commit_mode != 0) && p_commit && p_valid && p_ready;

  //--------------------------------------------------------------------------
  // read issue
  //--------------------------------------------------------------------------

  assign cur_rdptr_p1 = ptr_next(cur_rdptr, bound_low, bound_high);
  assign empty        = (wrptr == cur_rdptr);

  // issue when rb1 drains this cycle, or has room and nothing is in flight
  // either way the returning word is sure of a slot in rb1
  always_comb
  begin
    mem_re = 1'b0;
    if (!abort && !empty)
      mem_re = (ip_valid & ip_ready) | (rb1_ready & !prev_re);
  end

  // on abort, replay from the commit point, a same cycle commit included
  always_ff @(posedge clk)
  begin
    if (reset)
      cur_rdptr <= bound_low;
    else if (abort)
      cur_rdptr <= nxt_com_rdptr;
    else if (mem_re)
      cur_rdptr <= cur_rdptr_p1;
  end

  // marks ram data arriving this cycle, an in-flight read dies on abort
  always_ff @(posedge clk)
  begin
    if (reset || abort)
      prev_re <= 1'b0;
    else
      prev_re <= mem_re;
  end

  // address tag follows the ram read by one cycle
  always_ff @(posedge clk)
  begin
    if (mem_re)
      rdaddr_s0 <= cur_rdptr;
  end

  //--------------------------------------------------------------------------
  // commit pointer
  //--------------------------------------------------------------------------

  // a committed item releases everything up to and including itself
  always_comb
  begin
    if (commit_xfer)
      nxt_com_rdptr = ptr_next(fifo_ptr_t'(p_item.addr), bound_low, bound_high);
    else
      nxt_com_rdptr = com_rdptr;
  end

  generate
    if (commit_mode != 0)
    begin : gen_commit
      always_ff @(posedge clk)
      begin
        if (reset)
          com_rdptr <= bound_low;
        else
          com_rdptr <= nxt_com_rdptr;
      end
    end
    else
    begin : gen_no_commit
      // words are released as soon as they leave the ram
      assign com_rdptr = cur_rdptr;
    end
  endgenerate

  //--------------------------------------------------------------------------
  // output buffering
  //--------------------------------------------------------------------------

  assign flush         = reset | abort;
  assign ram_item.word = rd_data;
  assign ram_item.addr = rdaddr_s0;

  // rb1 catches the ram return, nothing stalls the ram data itself
  read_buffer rbuf1 (
    .clk       (clk),
    .reset     (flush),
    .in_valid  (prev_re),
    .in_ready  (rb1_ready),
    .in_item   (ram_item),
    .out_valid (ip_valid),
    .out_ready (ip_ready),
    .out_item  (ip_item)
  );

  // rb2 faces the consumer
  read_buffer rbuf2 (
    .clk       (clk),
    .reset     (flush),
    .in_valid  (ip_valid),
    .in_ready  (ip_ready),
    .in_item   (ip_item),
    .out_valid (p_valid),
    .out_ready (p_ready),
    .out_item  (p_item)
  );

  assign p_data = p_item.word;

  //--------------------------------------------------------------------------
  // usage
  //--------------------------------------------------------------------------

  // distance from commit to write pointer, modulo the region size
  always_comb
  begin
    fifo_size = {1'b0, bound_high} - {1'b0, bound_low} + fifo_usage_t'(1);
    if (wrptr >= com_rdptr)
      usage = {1'b0, wrptr} - {1'b0, com_rdptr};
    else
      usage = fifo_size - ({1'b0, com_rdptr} - {1'b0, wrptr});
  end

endmodule

`default_nettype wire

// File: logic/fifo_top.sv
//--------------------------------------------------------------------------
// memory backed fifo, head and tail controllers around a dual port ram
// set commit_mode for read/commit/abort and depth for the ram size
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_top
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
#(
  parameter int commit_mode = 1,
  parameter int depth       = 64
)
(
  input  wire logic       clk,
  input  wire logic       reset,

  // region bounds, stable from reset onward
  input  wire fifo_ptr_t  bound_low,
  input  wire fifo_ptr_t  bound_high,

  // producer port
  input  wire logic       c_valid,
  output logic            c_ready,
  input  wire fifo_word_t c_data,

  // consumer port
  output logic            p_valid,
  input  wire logic       p_ready,
  output fifo_word_t      p_data,
  input  wire logic       p_commit,
  input  wire logic       p_abort,

  // status
  output fifo_usage_t     usage
);

  // head to ram
  logic       mem_we;
  fifo_ptr_t  wr_addr;
  fifo_word_t wr_data;

  // between head and tail
  fifo_ptr_t  wrptr;
  fifo_ptr_t  com_rdptr;

  // tail and ram read port, the read pointer is the read address
  logic       mem_re;
  fifo_ptr_t  rd_addr;
  fifo_word_t rd_data;

  fifo_head head (
    .clk        (clk),
    .reset      (reset),
    .bound_low  (bound_low),
    .bound_high (bound_high),
    .com_rdptr  (com_rdptr),
    .c_valid    (c_valid),
    .c_ready    (c_ready),
    .c_data     (c_data),
    .wrptr      (wrptr),
    .mem_we     (mem_we),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  fifo_ram #(
    .depth (depth)
  ) ram (
    .clk     (clk),
    .mem_we  (mem_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .mem_re  (mem_re),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  fifo_tail #(
    .commit_mode (commit_mode)
  ) tail (
    .clk        (clk),
    .reset      (reset),
    .bound_low  (bound_low),
    .bound_high (bound_high),
    .wrptr      (wrptr),
    .cur_rdptr  (rd_addr),
    .com_rdptr  (com_rdptr),
    .mem_re     (mem_re),
    .rd_data    (rd_data),
    .p_valid    (p_valid),
    .p_ready    (p_ready),
    .p_data     (p_data),
    .p_commit   (p_commit),
    .p_abort    (p_abort),
    .usage      (usage)
  );

endmodule

`default_nettype wire

// File: testbench/fifo_assertions.sv
//--------------------------------------------------------------------------
// protocol assertions for the fifo ports that bind attaches to fifo_top
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_assertions
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire fifo_ptr_t   bound_low,
  input  wire fifo_ptr_t   bound_high,
  input  wire logic        c_ready,
  input  wire logic        p_valid,
  input  wire logic        p_ready,
  input  wire fifo_word_t  p_data,
  input  wire logic        p_abort,
  input  wire fifo_usage_t usage
);

  // number of ram words in the configured region
  fifo_usage_t region_size;

  // number of failed assertions so far
  int fail_count = 0;

  assign region_size = {1'b0, bound_high} - {1'b0, bound_low} + fifo_usage_t'(1);

  // a stalled output word holds unless an abort flushes it
  assert property (@(posedge clk) disable iff (reset)
    (p_valid && !p_ready && !p_abort) |=> $stable(p_data))
    else
    begin
      fail_count++;
      $error("p_data changed while p_valid was high and p_ready low");
    end

  // one slot stays free so size-1 words means full
  assert property (@(posedge clk) disable iff (reset)
    (usage == region_size - fifo_usage_t'(1)) |-> !c_ready)
    else
    begin
      fail_count++;
      $error("c_ready is high although the fifo is full");
    end

  // the output buffers are clear from the second reset cycle on
  assert property (@(posedge clk)
    (reset && $past(reset)) |-> !p_valid)
    else
    begin
      fail_count++;
      $error("p_valid is high during reset");
    end

endmodule

bind fifo_top fifo_assertions protocol_checks (
  .clk        (clk),
  .reset      (reset),
  .bound_low  (bound_low),
  .bound_high (bound_high),
  .c_ready    (c_ready),
  .p_valid    (p_valid),
  .p_ready    (p_ready),
  .p_data     (p_data),
  .p_abort    (p_abort),
  .usage      (usage)
);

`default_nettype wire

// File: testbench/fifo_checker.sv
//--------------------------------------------------------------------------
// watches the fifo ports and compares them with a queue based model
// of the written words, committed ones leave the front of the queue
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_checker
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire fifo_ptr_t   bound_low,
  input  wire fifo_ptr_t   bound_high,

  // producer port
  input  wire logic        c_valid,
  input  wire logic        c_ready,
  input  wire fifo_word_t  c_data,

  // consumer port
  input  wire logic        p_valid,
  input  wire logic        p_ready,
  input  wire fifo_word_t  p_data,
  input  wire logic        p_commit,
  input  wire logic        p_abort,
  input  wire fifo_usage_t usage,

  // one cycle request to compare usage with a table value
  input  wire logic        check_usage,
  input  wire fifo_usage_t exp_usage,

  output int               error_count
);

  // name of the running phase, set by the testbench
  string test_name = "none";

  // words between commit pointer and write pointer, oldest first
  logic [DATA_W-1:0] model_q [$];
  // index of the next word the consumer should see
  int                rd_idx;
  int                region;
  logic              exp_ready;

  initial
  begin
    error_count = 0;
    rd_idx      = 0;
  end

  task automatic report_mismatch(input string what, input int expected, input int actual);
    error_count++;
    $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
  endtask

  //--------------------------------------------------------------------------
  // sampling on the rising edge, inputs settle at the falling edge
  //--------------------------------------------------------------------------

  always @(posedge clk)
  begin
    if (reset)
    begin
      model_q.delete();
      rd_idx = 0;
    end
    else
    begin
      // state before this edge, c_ready and usage come from registers only
      region    = int'(bound_high) - int'(bound_low) + 1;
      exp_ready = (model_q.size() < region - 1);
      if (c_ready !== exp_ready)
        report_mismatch("c_ready", int'(exp_ready), int'(c_ready));
      if (int'(usage) != model_q.size())
        report_mismatch("usage vs model", model_q.size(), int'(usage));
      if (check_usage && (usage !== exp_usage))
        report_mismatch("usage at rest", int'(exp_usage), int'(usage));

      // producer transfer
      if (c_valid && c_ready)
        model_q.push_back(c_data.data);

      // consumer transfer, a commit releases everything up to this word
      if (p_valid && p_ready)
      begin
        if (rd_idx >= model_q.size())
        begin
          error_count++;
          $display("ERROR in %s: consumer received a word that was never written",
                   test_name);
        end
        else
        begin
          if (p_data.data !== model_q[rd_idx])
            report_mismatch("p_data", int'(model_q[rd_idx]), int'(p_data.data));
          rd_idx++;
          if (p_commit)
          begin
            repeat (rd_idx) void'(model_q.pop_front());
            rd_idx = 0;
          end
        end
      end

      // abort replays from the last commit
      if (p_abort)
        rd_idx = 0;
    end
  end

endmodule

`default_nettype wire

// File: testbench/fifo_tb.sv
//--------------------------------------------------------------------------
// testbench for fifo_top that runs a table of phases through producer and
// consumer tasks while fifo_checker compares every transfer
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module fifo_tb
  import fifo_ptr_pkg::*, fifo_data_pkg::*;
;

  localparam int TIMEOUT    = 500;
  localparam int NUM_PHASES = 8;

  // consumer actions per phase
  localparam logic [1:0] ACT_COMMIT = 2'd0;
  localparam logic [1:0] ACT_ABORT  = 2'd1;
  localparam logic [1:0] ACT_HOLD   = 2'd2;

  // one row of the stimulus table
  typedef struct packed {
    fifo_ptr_t   low;
    fifo_ptr_t   high;
    logic [7:0]  n_write;
    logic [7:0]  n_read;
    logic        rand_ready;
    logic [1:0]  action;
    fifo_usage_t exp_usage;
  } phase_t;

  logic        clk;
  logic        reset;
  fifo_ptr_t   bound_low;
  fifo_ptr_t   bound_high;
  logic        c_valid;
  logic        c_ready;
  fifo_word_t  c_data;
  logic        p_valid;
  logic        p_ready;
  fifo_word_t  p_data;
  logic        p_commit;
  logic        p_abort;
  fifo_usage_t usage;
  logic        check_usage;
  fifo_usage_t exp_usage;
  int          chk_errors;

  phase_t      phases [NUM_PHASES];
  string       names [NUM_PHASES];
  integer      seed;
  integer      ready_seed;
  logic        rand_ready;
  int          timeouts;

  fifo_top #(
    .commit_mode (1),
    .depth       (64)
  ) dut (
    .clk        (clk),
    .reset      (reset),
    .bound_low  (bound_low),
    .bound_high (bound_high),
    .c_valid    (c_valid),
    .c_ready    (c_ready),
    .c_data     (c_data),
    .p_valid    (p_valid),
    .p_ready    (p_ready),
    .p_data     (p_data),
    .p_commit   (p_commit),
    .p_abort    (p_abort),
    .usage      (usage)
  );

  fifo_checker chk (
    .clk         (clk),
    .reset       (reset),
    .bound_low   (bound_low),
    .bound_high  (bound_high),
    .c_valid     (c_valid),
    .c_ready     (c_ready),
    .c_data      (c_data),
    .p_valid     (p_valid),
    .p_ready     (p_ready),
    .p_data      (p_data),
    .p_commit    (p_commit),
    .p_abort     (p_abort),
    .usage       (usage),
    .check_usage (check_usage),
    .exp_usage   (exp_usage),
    .error_count (chk_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // run control
  //--------------------------------------------------------------------------

  task automatic finish_run();
    int assert_fails;
    assert_fails = dut.protocol_checks.fail_count;
    $display("closing counts: %0d check errors, %0d assertion failures, %0d timeouts",
             chk_errors, assert_fails, timeouts);
    if (chk_errors == 0 && assert_fails == 0 && timeouts == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeouts++;
    $display("timeout in %s: %s", chk.test_name, what);
    finish_run();
  endtask

  // bounds go in before reset and reset is held for 8 cycles
  task automatic apply_reset(input fifo_ptr_t low, input fifo_ptr_t high);
    @(negedge clk);
    bound_low  = low;
    bound_high = high;
    reset      = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // producer and consumer
  //--------------------------------------------------------------------------

  // c_ready seen at the falling edge means a transfer on the next rise
  task automatic write_words(input int n);
    int          k;
    int          waited;
    logic [31:0] rnd;
    for (k = 0; k < n; k++)
    begin
      rnd = $random(seed);
      @(negedge clk);
      c_valid     = 1'b1;
      c_data.data = rnd[DATA_W-1:0];
      waited      = 0;
      while (!c_ready)
      begin
        waited++;
        if (waited > TIMEOUT)
          stop_on_timeout("producer waited too long for c_ready");
        @(negedge clk);
      end
    end
    @(negedge clk);
    c_valid = 1'b0;
  endtask

  // p_valid is a register and holds from the falling to the rising edge
  task automatic read_words(input int n, input logic with_commit);
    int          got;
    int          waited;
    logic [31:0] rnd;
    got    = 0;
    waited = 0;
    while (got < n)
    begin
      @(negedge clk);
      rnd      = $random(ready_seed);
      p_ready  = rand_ready ? (rnd[1:0] != 2'b00) : 1'b1;
      p_commit = with_commit;
      if (p_valid && p_ready)
      begin
        got++;
        waited = 0;
      end
      else
      begin
        waited++;
        if (waited > TIMEOUT)
          stop_on_timeout("consumer waited too long for p_valid");
      end
    end
    @(negedge clk);
    p_ready  = 1'b0;
    p_commit = 1'b0;
  endtask

  // one cycle pulse with the consumer stalled
  task automatic send_abort();
    @(negedge clk);
    p_ready = 1'b0;
    p_abort = 1'b1;
    @(negedge clk);
    p_abort = 1'b0;
  endtask

  task automatic consume(input phase_t ph);
    case (ph.action)
      ACT_COMMIT:
        read_words(int'(ph.n_read), 1'b1);
      ACT_ABORT:
      begin
        read_words(int'(ph.n_read), 1'b0);
        send_abort();
        read_words(int'(ph.n_read), 1'b1);
      end
      default:
        read_words(int'(ph.n_read), 1'b0);
    endcase
  endtask

  // idle a few cycles and then ask the checker for a usage compare
  task automatic request_usage_check(input fifo_usage_t expected);
    repeat (5) @(negedge clk);
    exp_usage   = expected;
    check_usage = 1'b1;
    @(negedge clk);
    check_usage = 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // phase table and main loop
  //--------------------------------------------------------------------------

  initial
  begin
    int     i;
    logic   need_reset;
    phase_t ph;
    reset       = 1'b1;
    bound_low   = 6'd0;
    bound_high  = 6'd63;
    c_valid     = 1'b0;
    c_data      = '0;
    p_ready     = 1'b0;
    p_commit    = 1'b0;
    p_abort     = 1'b0;
    check_usage = 1'b0;
    exp_usage   = '0;
    rand_ready  = 1'b0;
    timeouts    = 0;
    seed        = 32'h2d33_a6a0;
    ready_seed  = seed ^ 32'h0000_ffff;

    // name, low, high, writes, reads, random ready, action, usage at rest
    names[0] = "stream";
    phases[0] = '{6'd0, 6'd63, 8'd40, 8'd40, 1'b1, ACT_COMMIT, 7'd0};
    names[1] = "fill";
    phases[1] = '{6'd5, 6'd14, 8'd9, 8'd0, 1'b0, ACT_COMMIT, 7'd9};
    names[2] = "wrap";
    phases[2] = '{6'd5, 6'd14, 8'd9, 8'd18, 1'b1, ACT_COMMIT, 7'd0};
    names[3] = "abort";
    phases[3] = '{6'd5, 6'd14, 8'd6, 8'd6, 1'b1, ACT_ABORT, 7'd0};
    names[4] = "hold";
    phases[4] = '{6'd5, 6'd14, 8'd9, 8'd8, 1'b0, ACT_HOLD, 7'd9};
    // the first read commits the 9 held words and new words follow
    names[5] = "release";
    phases[5] = '{6'd5, 6'd14, 8'd4, 8'd5, 1'b1, ACT_COMMIT, 7'd0};
    // words left waiting at the output when the next reset comes
    names[6] = "pending";
    phases[6] = '{6'd0, 6'd63, 8'd3, 8'd0, 1'b0, ACT_HOLD, 7'd3};
    // reset with p_valid high must drop the pending words
    names[7] = "flush";
    phases[7] = '{6'd5, 6'd14, 8'd2, 8'd2, 1'b1, ACT_COMMIT, 7'd0};

    for (i = 0; i < NUM_PHASES; i++)
    begin
      ph            = phases[i];
      chk.test_name = names[i];
      // new bounds only take effect through reset
      if (i == 0)
        need_reset = 1'b1;
      else
        need_reset = (ph.low != phases[i-1].low) || (ph.high != phases[i-1].high);
      if (need_reset)
        apply_reset(ph.low, ph.high);
      rand_ready = ph.rand_ready;
      fork
        write_words(int'(ph.n_write));
        consume(ph);
      join
      request_usage_check(ph.exp_usage);
    end

    repeat (2) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: build.f
logic/fifo_ptr_pkg.sv
logic/fifo_data_pkg.sv
logic/read_buffer.sv
logic/fifo_head.sv
logic/fifo_ram.sv
logic/fifo_tail.sv
logic/fifo_top.sv
testbench/fifo_assertions.sv
testbench/fifo_checker.sv
testbench/fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the fifo testbench with verilator, run it, and judge the log

log=sim.log

verilator --binary --timing --assert -f build.f --top-module fifo_tb -o fifo_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/fifo_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$log"; then
  echo "simulation reported errors"
  exit 1
fi

exit 0
